// File: src/primQuery_macros.svh
//--------------------------------------------------------------------
// Sizes and scene constants for the primitive query unit
// The top bit of an index marks null, so keep store depths below 128
//--------------------------------------------------------------------
`ifndef PRIM_QUERY_MACROS_SVH
`define PRIM_QUERY_MACROS_SVH

// Index format
`define PRIM_INDEX_WIDTH 8
`define PRIM_NULL_INDEX  {`PRIM_INDEX_WIDTH{1'b1}}

// Lanes returned per query
`define PRIM_LANES 2

// Scene store depths
`define AABB_DEPTH   8
`define SPHERE_DEPTH 4

// Signed fixed point, 16.16
`define FIXED_WIDTH 32
`define FIXED_FRAC  16
`define COLOR_WIDTH 8

// Box index that receives the scene offset
`define OFFSET_INDEX 1

// Surface classes by primitive index
`define DIELECTRIC_INDEX 1
`define METAL_INDEX      2

`endif

// File: src/primQueryPkg.sv
//--------------------------------------------------------------------
// Shared types of the primitive query unit and its testbench
//--------------------------------------------------------------------
`include "primQuery_macros.svh"

package primQueryPkg;

    // One signed fixed-point value
    typedef logic signed [`FIXED_WIDTH-1:0] fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } fixed3_t;

    typedef struct packed {
        logic [`COLOR_WIDTH-1:0] r;
        logic [`COLOR_WIDTH-1:0] g;
        logic [`COLOR_WIDTH-1:0] b;
    } rgb8_t;

    // Query opcode
    typedef enum logic {
        PrimAabb,
        PrimSphere
    } primKind_e;

    typedef enum logic [1:0] {
        SurfNone,
        SurfLambertian,
        SurfMetal,
        SurfDielectric
    } surface_e;

    typedef struct packed {
        primKind_e                    kind;
        logic [`PRIM_INDEX_WIDTH-1:0] startIndex;
        // Exclusive upper bound
        logic [`PRIM_INDEX_WIDTH-1:0] endIndex;
    } primQuery_t;

    // One lane in flight
    typedef struct packed {
        logic [`PRIM_INDEX_WIDTH-1:0] index;
        logic                         valid;
        primKind_e                    kind;
    } laneCtl_t;

    typedef struct packed {
        logic [`PRIM_INDEX_WIDTH-1:0] primIndex;
        surface_e                     surface;
        rgb8_t                        color;
        fixed3_t                      boxMin;
        fixed3_t                      boxMax;
    } aabbPrim_t;

    typedef struct packed {
        logic [`PRIM_INDEX_WIDTH-1:0] primIndex;
        surface_e                     surface;
        rgb8_t                        color;
        fixed3_t                      center;
        fixed_t                       radius;
    } spherePrim_t;

    // Execute to result, one element per lane in each field
    typedef struct packed {
        laneCtl_t [`PRIM_LANES-1:0] ctl;
        rgb8_t    [`PRIM_LANES-1:0] color;
        fixed3_t  [`PRIM_LANES-1:0] boxMin;
        fixed3_t  [`PRIM_LANES-1:0] boxMax;
        fixed3_t  [`PRIM_LANES-1:0] center;
        fixed_t   [`PRIM_LANES-1:0] radius;
    } fetchOut_t;

endpackage

// File: src/queryDecode.sv
//--------------------------------------------------------------------
// Decode stage, one cycle. Lane controls and offset load only on a
// query strobe and hold otherwise
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "primQuery_macros.svh"

module queryDecode (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    queryValid,
    input  primQueryPkg::primQuery_t query,
    input  primQueryPkg::fixed3_t    offset,
    output logic                    laneValid,
    output primQueryPkg::laneCtl_t   lanes [`PRIM_LANES],
    output primQueryPkg::fixed3_t    laneOffset
);
    import primQueryPkg::*;

    laneCtl_t                     nextLanes [`PRIM_LANES];
    logic [`PRIM_INDEX_WIDTH-1:0] laneIndex [`PRIM_LANES];
    logic                         inRange   [`PRIM_LANES];

    //----------------------------------------------------------------
    // Lane index and validity
    //----------------------------------------------------------------
    always_comb begin
        for (int l = 0; l < `PRIM_LANES; l++) begin
            // Consecutive indices from the start
            laneIndex[l] = query.startIndex + `PRIM_INDEX_WIDTH'(l);
            // Depth depends on the kind
            if (query.kind == PrimAabb) begin
                inRange[l] = laneIndex[l] < `AABB_DEPTH;
            end else begin
                inRange[l] = laneIndex[l] < `SPHERE_DEPTH;
            end
            nextLanes[l].kind  = query.kind;
            // Null start, end bound and depth
            nextLanes[l].valid = !query.startIndex[`PRIM_INDEX_WIDTH-1]
                               && (laneIndex[l] < query.endIndex)
                               && inRange[l];
            nextLanes[l].index = nextLanes[l].valid ? laneIndex[l] : `PRIM_NULL_INDEX;
        end
    end

    //----------------------------------------------------------------
    // Stage registers
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            laneValid <= 1'b0;
            for (int l = 0; l < `PRIM_LANES; l++) begin
                lanes[l] <= '0;
            end
        end else begin
            laneValid <= queryValid;
            if (queryValid) begin
                lanes <= nextLanes;
            end
        end
    end

    // Offset rides along with the lanes
    always_ff @(posedge clk) begin
        if (queryValid) begin
            laneOffset <= offset;
        end
    end

endmodule

// File: src/primitiveFetch.sv
//--------------------------------------------------------------------
// Execute stage with the built-in scene. Stores are loaded at reset
// only, entries not in the scene read as zero
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "primQuery_macros.svh"

module primitiveFetch (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    laneValid,
    input  primQueryPkg::laneCtl_t   lanes [`PRIM_LANES],
    input  primQueryPkg::fixed3_t    laneOffset,
    output logic                    fetchValid,
    output primQueryPkg::fetchOut_t  fetched
);
    import primQueryPkg::*;

    // Center, half-size or radius, colour
    typedef struct packed {
        fixed3_t center;
        fixed_t  size;
        rgb8_t   color;
    } sceneEntry_t;

    sceneEntry_t aabbStore   [`AABB_DEPTH];
    sceneEntry_t sphereStore [`SPHERE_DEPTH];

    sceneEntry_t boxEntry    [`PRIM_LANES];
    sceneEntry_t sphEntry    [`PRIM_LANES];
    fixed3_t     boxShift    [`PRIM_LANES];

    laneCtl_t    ctlQ        [`PRIM_LANES];
    rgb8_t       colorQ      [`PRIM_LANES];
    fixed3_t     minQ        [`PRIM_LANES];
    fixed3_t     maxQ        [`PRIM_LANES];
    fixed3_t     centerQ     [`PRIM_LANES];
    fixed_t      radiusQ     [`PRIM_LANES];

    function automatic fixed_t toFixed(input int v);
        return fixed_t'(v) <<< `FIXED_FRAC;
    endfunction

    function automatic sceneEntry_t sceneEntry(input int cx, input int cy, input int cz,
                                               input int size, input rgb8_t color);
        return '{center: '{x: toFixed(cx), y: toFixed(cy), z: toFixed(cz)},
                 size: toFixed(size), color: color};
    endfunction

    // Per-axis add of a vector and a scalar
    function automatic fixed3_t addScalar(input fixed3_t a, input fixed_t s);
        return '{x: a.x + s, y: a.y + s, z: a.z + s};
    endfunction

    function automatic fixed3_t addVector(input fixed3_t a, input fixed3_t b);
        return '{x: a.x + b.x, y: a.y + b.y, z: a.z + b.z};
    endfunction

    //----------------------------------------------------------------
    // Scene stores
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int e = 0; e < `AABB_DEPTH; e++) begin
                aabbStore[e] <= '0;
            end
            for (int e = 0; e < `SPHERE_DEPTH; e++) begin
                sphereStore[e] <= '0;
            end
            // Ground slab
            aabbStore[0]   <= sceneEntry(0, -256, 0, 256, '{8'd100, 8'd255, 8'd100});
            aabbStore[1]   <= sceneEntry(0, 13, 0, 10, '{8'd255, 8'd255, 8'd145});
            aabbStore[2]   <= sceneEntry(0, 20, 60, 20, '{8'd255, 8'd100, 8'd125});
            sphereStore[0] <= sceneEntry(0, 16, 0, 16, '{8'd255, 8'd255, 8'd0});
        end
    end

    //----------------------------------------------------------------
    // Record read and bounds
    //----------------------------------------------------------------
    always_comb begin
        for (int l = 0; l < `PRIM_LANES; l++) begin
            // Null lanes wrap harmlessly into the store
            boxEntry[l] = aabbStore[lanes[l].index % `AABB_DEPTH];
            sphEntry[l] = sphereStore[lanes[l].index % `SPHERE_DEPTH];
            boxShift[l] = (lanes[l].index == `OFFSET_INDEX) ? laneOffset : '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchValid <= 1'b0;
            for (int l = 0; l < `PRIM_LANES; l++) begin
                ctlQ[l] <= '0;
            end
        end else begin
            fetchValid <= laneValid;
            if (laneValid) begin
                ctlQ <= lanes;
            end
        end
    end

    // Geometry payload
    always_ff @(posedge clk) begin
        if (laneValid) begin
            for (int l = 0; l < `PRIM_LANES; l++) begin
                colorQ[l]  <= (lanes[l].kind == PrimAabb) ? boxEntry[l].color
                                                          : sphEntry[l].color;
                minQ[l]    <= addVector(addScalar(boxEntry[l].center, -boxEntry[l].size),
                                        boxShift[l]);
                maxQ[l]    <= addVector(addScalar(boxEntry[l].center, boxEntry[l].size),
                                        boxShift[l]);
                centerQ[l] <= sphEntry[l].center;
                radiusQ[l] <= sphEntry[l].size;
            end
        end
    end

    // Pack lanes for the result stage
    always_comb begin
        for (int l = 0; l < `PRIM_LANES; l++) begin
            fetched.ctl[l]    = ctlQ[l];
            fetched.color[l]  = colorQ[l];
            fetched.boxMin[l] = minQ[l];
            fetched.boxMax[l] = maxQ[l];
            fetched.center[l] = centerQ[l];
            fetched.radius[l] = radiusQ[l];
        end
    end

endmodule

// File: src/resultAssemble.sv
//--------------------------------------------------------------------
// Result stage, refraction surface classes. Outputs hold between
// results and read as zero after reset
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "primQuery_macros.svh"

module resultAssemble (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      fetchValid,
    input  primQueryPkg::fetchOut_t    fetched,
    output logic                      resultValid,
    output primQueryPkg::aabbPrim_t    aabbOut   [`PRIM_LANES],
    output primQueryPkg::spherePrim_t  sphereOut [`PRIM_LANES]
);
    import primQueryPkg::*;

    aabbPrim_t   nextAabb   [`PRIM_LANES];
    spherePrim_t nextSphere [`PRIM_LANES];

    // Surface class from the primitive index
    function automatic surface_e classify(input logic [`PRIM_INDEX_WIDTH-1:0] index);
        if (index == `DIELECTRIC_INDEX) begin
            return SurfDielectric;
        end else if (index == `METAL_INDEX) begin
            return SurfMetal;
        end
        return SurfLambertian;
    endfunction

    //----------------------------------------------------------------
    // Route lanes by kind
    //----------------------------------------------------------------
    always_comb begin
        for (int l = 0; l < `PRIM_LANES; l++) begin
            // Null lane by default, all fields zero
            nextAabb[l]             = '0;
            nextAabb[l].primIndex   = `PRIM_NULL_INDEX;
            nextSphere[l]           = '0;
            nextSphere[l].primIndex = `PRIM_NULL_INDEX;
            if (fetched.ctl[l].valid) begin
                if (fetched.ctl[l].kind == PrimAabb) begin
                    nextAabb[l].primIndex = fetched.ctl[l].index;
                    nextAabb[l].surface   = classify(fetched.ctl[l].index);
                    nextAabb[l].color     = fetched.color[l];
                    nextAabb[l].boxMin    = fetched.boxMin[l];
                    nextAabb[l].boxMax    = fetched.boxMax[l];
                end else begin
                    nextSphere[l].primIndex = fetched.ctl[l].index;
                    nextSphere[l].surface   = classify(fetched.ctl[l].index);
                    nextSphere[l].color     = fetched.color[l];
                    nextSphere[l].center    = fetched.center[l];
                    nextSphere[l].radius    = fetched.radius[l];
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Output registers
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
            for (int l = 0; l < `PRIM_LANES; l++) begin
                aabbOut[l]   <= '0;
                sphereOut[l] <= '0;
            end
        end else begin
            resultValid <= fetchValid;
            if (fetchValid) begin
                aabbOut   <= nextAabb;
                sphereOut <= nextSphere;
            end
        end
    end

endmodule

// File: src/primitiveUnit.sv
//--------------------------------------------------------------------
// Primitive query unit, three stages and no back-pressure
// One query per clock, results three cycles later in order
//--------------------------------------------------------------------
`timescale 1ns/10ps
`include "primQuery_macros.svh"

module primitiveUnit (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      queryValid,
    input  primQueryPkg::primQuery_t   query,
    input  primQueryPkg::fixed3_t      offset,
    output logic                      resultValid,
    output primQueryPkg::aabbPrim_t    aabbOut   [`PRIM_LANES],
    output primQueryPkg::spherePrim_t  sphereOut [`PRIM_LANES]
);
    import primQueryPkg::*;

    // Decode to execute
    logic      laneValid;
    laneCtl_t  lanes [`PRIM_LANES];
    fixed3_t   laneOffset;

    // Execute to result
    logic      fetchValid;
    fetchOut_t fetched;

    queryDecode decodeStage (
        .clk        (clk),
        .arstN      (arstN),
        .queryValid (queryValid),
        .query      (query),
        .offset     (offset),
        .laneValid  (laneValid),
        .lanes      (lanes),
        .laneOffset (laneOffset)
    );

    primitiveFetch fetchStage (
        .clk        (clk),
        .arstN      (arstN),
        .laneValid  (laneValid),
        .lanes      (lanes),
        .laneOffset (laneOffset),
        .fetchValid (fetchValid),
        .fetched    (fetched)
    );

    resultAssemble resultStage (
        .clk         (clk),
        .arstN       (arstN),
        .fetchValid  (fetchValid),
        .fetched     (fetched),
        .resultValid (resultValid),
        .aabbOut     (aabbOut),
        .sphereOut   (sphereOut)
    );

endmodule

// File: tb/primitiveUnit_properties.sv
//----------------------------------------------------------------------
// Timing and lane checks for primitiveUnit, assumes a free-running clock
//----------------------------------------------------------------------
`timescale 1ns/10ps
`include "primQuery_macros.svh"

module primitiveUnit_properties (
    input logic                      clk,
    input logic                      arstN,
    input logic                      queryValid,
    input logic                      resultValid,
    input primQueryPkg::aabbPrim_t   aabbOut   [`PRIM_LANES],
    input primQueryPkg::spherePrim_t sphereOut [`PRIM_LANES]
);
    import primQueryPkg::*;

    int unsigned failures = 0;

    //------------------------------------------------------------------
    // Pipeline timing
    //------------------------------------------------------------------
    // Every query gives a result three cycles on
    latencyForward: assert property (
        @(posedge clk) disable iff (!arstN) queryValid |-> ##3 resultValid
    ) else begin
        failures++;
        $error("Result strobe missing three cycles after a query");
    end

    // No result without a query
    latencyBackward: assert property (
        @(posedge clk) disable iff (!arstN) resultValid |-> $past(queryValid, 3)
    ) else begin
        failures++;
        $error("Result strobe without a query three cycles earlier");
    end

    quietInReset: assert property (
        @(posedge clk) !arstN |-> !resultValid
    ) else begin
        failures++;
        $error("Result strobe high during reset");
    end

    //------------------------------------------------------------------
    // Per lane consistency
    //------------------------------------------------------------------
    for (genvar l = 0; l < `PRIM_LANES; l++) begin : laneChecks
        // Null lanes carry no surface
        nullBox: assert property (
            @(posedge clk) disable iff (!arstN)
            aabbOut[l].primIndex[`PRIM_INDEX_WIDTH-1] |-> aabbOut[l].surface == SurfNone
        ) else begin
            failures++;
            $error("Null box lane with a surface");
        end

        nullSphere: assert property (
            @(posedge clk) disable iff (!arstN)
            sphereOut[l].primIndex[`PRIM_INDEX_WIDTH-1] |-> sphereOut[l].surface == SurfNone
        ) else begin
            failures++;
            $error("Null sphere lane with a surface");
        end

        // Corners ordered on every axis
        boxOrder: assert property (
            @(posedge clk) disable iff (!arstN)
            resultValid && !aabbOut[l].primIndex[`PRIM_INDEX_WIDTH-1]
            |-> aabbOut[l].boxMax.x >= aabbOut[l].boxMin.x
                && aabbOut[l].boxMax.y >= aabbOut[l].boxMin.y
                && aabbOut[l].boxMax.z >= aabbOut[l].boxMin.z
        ) else begin
            failures++;
            $error("Box lane with max below min");
        end
    end

endmodule

bind primitiveUnit primitiveUnit_properties checks (
    .clk         (clk),
    .arstN       (arstN),
    .queryValid  (queryValid),
    .resultValid (resultValid),
    .aabbOut     (aabbOut),
    .sphereOut   (sphereOut)
);

// File: tb/primitiveUnit_tb.sv
//----------------------------------------------------------------------
// Testbench for primitiveUnit. Results are matched to queries strictly
// in order of issue against a model of the built-in scene
//----------------------------------------------------------------------
`timescale 1ns/10ps
`include "primQuery_macros.svh"

module primitiveUnit_tb;
    import primQueryPkg::*;

    typedef aabbPrim_t   [`PRIM_LANES-1:0] aabbLanes_t;
    typedef spherePrim_t [`PRIM_LANES-1:0] sphereLanes_t;

    // One scene entry in whole units
    typedef struct packed {
        int    cx;
        int    cy;
        int    cz;
        int    size;
        rgb8_t color;
    } sceneRow_t;

    logic        clk;
    logic        arstN;
    logic        queryValid;
    primQuery_t  query;
    fixed3_t     offset;
    logic        resultValid;
    aabbPrim_t   aabbOut   [`PRIM_LANES];
    spherePrim_t sphereOut [`PRIM_LANES];

    // Expected results with the oldest first
    aabbLanes_t   expAabb   [$];
    sphereLanes_t expSphere [$];
    int           valueErrors = 0;
    int           timeouts = 0;
    logic [31:0]  lfsr = 32'had7e59db;

    primitiveUnit UUT (
        .clk         (clk),
        .arstN       (arstN),
        .queryValid  (queryValid),
        .query       (query),
        .offset      (offset),
        .resultValid (resultValid),
        .aabbOut     (aabbOut),
        .sphereOut   (sphereOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //------------------------------------------------------------------
    // Random source
    //------------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic nextBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    // Small signed offset within 8 units either way
    function automatic fixed_t randomFixed();
        logic [19:0] v;
        v = 20'(randomBits(20));
        return fixed_t'($signed(v));
    endfunction

    //------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------
    function automatic fixed_t units(input int v);
        return fixed_t'(v * (1 << `FIXED_FRAC));
    endfunction

    function automatic sceneRow_t sceneRow(input primKind_e kind, input int idx);
        sceneRow_t r;
        r = '0;
        if (kind == PrimAabb) begin
            case (idx)
                0: r = '{0, -256, 0, 256, '{8'd100, 8'd255, 8'd100}};
                1: r = '{0, 13, 0, 10, '{8'd255, 8'd255, 8'd145}};
                2: r = '{0, 20, 60, 20, '{8'd255, 8'd100, 8'd125}};
                default: r = '0;
            endcase
        end else if (idx == 0) begin
            r = '{0, 16, 0, 16, '{8'd255, 8'd255, 8'd0}};
        end
        return r;
    endfunction

    function automatic surface_e surfaceOf(input int idx);
        if (idx == `DIELECTRIC_INDEX) begin
            return SurfDielectric;
        end
        if (idx == `METAL_INDEX) begin
            return SurfMetal;
        end
        return SurfLambertian;
    endfunction

    function automatic void expectLanes(input primQuery_t q, input fixed3_t off);
        aabbLanes_t   a;
        sphereLanes_t s;
        sceneRow_t    row;
        fixed3_t      shift;
        int           idx;
        int           depth;
        depth = (q.kind == PrimAabb) ? `AABB_DEPTH : `SPHERE_DEPTH;
        for (int l = 0; l < `PRIM_LANES; l++) begin
            idx            = q.startIndex + l;
            a[l]           = '0;
            a[l].primIndex = `PRIM_NULL_INDEX;
            s[l]           = '0;
            s[l].primIndex = `PRIM_NULL_INDEX;
            if (!q.startIndex[`PRIM_INDEX_WIDTH-1] && idx < int'(q.endIndex)
                    && idx < depth) begin
                row = sceneRow(q.kind, idx);
                if (idx == `OFFSET_INDEX) begin
                    shift = off;
                end else begin
                    shift = '0;
                end
                if (q.kind == PrimAabb) begin
                    a[l].primIndex = `PRIM_INDEX_WIDTH'(idx);
                    a[l].surface   = surfaceOf(idx);
                    a[l].color     = row.color;
                    a[l].boxMin.x  = units(row.cx - row.size) + shift.x;
                    a[l].boxMin.y  = units(row.cy - row.size) + shift.y;
                    a[l].boxMin.z  = units(row.cz - row.size) + shift.z;
                    a[l].boxMax.x  = units(row.cx + row.size) + shift.x;
                    a[l].boxMax.y  = units(row.cy + row.size) + shift.y;
                    a[l].boxMax.z  = units(row.cz + row.size) + shift.z;
                end else begin
                    s[l].primIndex = `PRIM_INDEX_WIDTH'(idx);
                    s[l].surface   = surfaceOf(idx);
                    s[l].color     = row.color;
                    s[l].center    = '{units(row.cx), units(row.cy), units(row.cz)};
                    s[l].radius    = units(row.size);
                end
            end
        end
        expAabb.push_back(a);
        expSphere.push_back(s);
    endfunction

    // Model sees exactly what the DUT samples
    always @(posedge clk) begin
        if (arstN && queryValid) begin
            expectLanes(query, offset);
        end
    end

    //------------------------------------------------------------------
    // Checking
    //------------------------------------------------------------------
    task automatic compareResult(input aabbLanes_t a, input sphereLanes_t s);
        for (int l = 0; l < `PRIM_LANES; l++) begin
            assert (aabbOut[l] === a[l]) else begin
                valueErrors++;
                $display("ERROR %0t: box lane %0d got %h expected %h",
                         $time, l, aabbOut[l], a[l]);
            end
            assert (sphereOut[l] === s[l]) else begin
                valueErrors++;
                $display("ERROR %0t: sphere lane %0d got %h expected %h",
                         $time, l, sphereOut[l], s[l]);
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arstN && resultValid) begin
            if (expAabb.size() == 0) begin
                valueErrors++;
                $display("Result strobe seen with no query outstanding at %0t", $time);
            end else begin
                compareResult(expAabb.pop_front(), expSphere.pop_front());
            end
        end
    end

    task automatic checkIdle();
        for (int l = 0; l < `PRIM_LANES; l++) begin
            assert (!resultValid && aabbOut[l] == '0 && sphereOut[l] == '0) else begin
                valueErrors++;
                $display("ERROR %0t: lane %0d not quiet after reset", $time, l);
            end
        end
    endtask

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------
    task automatic sendQuery(input primQuery_t q, input fixed3_t off);
        @(negedge clk);
        queryValid = 1'b1;
        query      = q;
        offset     = off;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            queryValid = 1'b0;
        end
    endtask

    task automatic drainResults();
        int cycles;
        cycles = 0;
        while (expAabb.size() != 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (expAabb.size() != 0) begin
            timeouts++;
            $display("Timed out waiting for %0d outstanding results", expAabb.size());
        end
    endtask

    initial begin
        primQuery_t rq;
        fixed3_t    shift;
        fixed3_t    noOffset;
        fixed3_t    rOff;
        arstN      = 1'b0;
        queryValid = 1'b0;
        query      = '0;
        offset     = '0;
        noOffset   = '0;
        shift      = '{units(3), units(-2), fixed_t'(32'h0000_8000)};
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkIdle();

        // Back to back box queries with the offset on index 1 only
        sendQuery('{PrimAabb, 8'd0, 8'd3}, shift);
        sendQuery('{PrimAabb, 8'd2, 8'd3}, shift);
        idleCycles(2);
        // Sphere decode leaves every box lane null
        sendQuery('{PrimSphere, 8'd0, 8'd2}, noOffset);
        idleCycles(4);

        // End bound, store depth and null start
        sendQuery('{PrimAabb, 8'd1, 8'd2}, shift);
        sendQuery('{PrimAabb, 8'd7, 8'd9}, noOffset);
        sendQuery('{PrimSphere, 8'd3, 8'd5}, noOffset);
        sendQuery('{PrimAabb, 8'd128, 8'd200}, shift);
        sendQuery('{PrimSphere, 8'd255, 8'd255}, noOffset);
        // Surface classes of both kinds on empty entries too
        sendQuery('{PrimSphere, 8'd1, 8'd3}, noOffset);
        sendQuery('{PrimAabb, 8'd3, 8'd8}, noOffset);
        idleCycles(1);

        // Random mix of back to back and spaced queries
        for (int i = 0; i < 200; i++) begin
            rq.kind = primKind_e'(nextBit());
            if (nextBit()) begin
                rq.startIndex = 8'(randomBits(8));
            end else begin
                rq.startIndex = 8'(randomBits(3));
            end
            rq.endIndex = 8'(randomBits(4));
            rOff.x      = randomFixed();
            rOff.y      = randomFixed();
            rOff.z      = randomFixed();
            sendQuery(rq, rOff);
            if (nextBit()) begin
                idleCycles(1);
            end
        end
        idleCycles(1);
        drainResults();

        $display("Value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 valueErrors, timeouts, UUT.checks.failures);
        if (valueErrors == 0 && timeouts == 0 && UUT.checks.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/primQueryPkg.sv
src/queryDecode.sv
src/primitiveFetch.sv
src/resultAssemble.sv
src/primitiveUnit.sv
tb/primitiveUnit_properties.sv
tb/primitiveUnit_tb.sv
